/* Makefile */
TOP = cpuDatapath_tb

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f cpuDatapath.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "CHECKS FAILED" sim.log || ! grep -q "ALL CHECKS PASSED" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

/* cpuDatapath.f */
logic/cpuPkg.sv
logic/regFile.sv
logic/aluUnit.sv
logic/instrDecoder.sv
logic/hazardUnit.sv
logic/cpuDatapath.sv
test/cpuDatapath_sva.sv
test/cpuDatapath_tb.sv

/* logic/aluUnit.sv */
`timescale 1ns/1ns

module aluUnit (
    input  cpuPkg::wordT  opA,
    input  cpuPkg::wordT  opB,
    input  cpuPkg::aluOpT aluOp,
    output cpuPkg::wordT  result
);
    import cpuPkg::*;

    // also computes load/store addresses (rs + imm)
    always_comb begin
        case (aluOp)
            aluAdd: begin
                result = opA + opB;
            end
            aluSub: begin
                result = opA - opB;
            end
            aluAnd: begin
                result = opA & opB;
            end
            aluOr: begin
                result = opA | opB;
            end
            default: begin
                result = opA + opB;
            end
        endcase
    end

endmodule

/* logic/cpuDatapath.sv */
`timescale 1ns/1ns

module cpuDatapath (
    input  logic         clk,
    input  logic         rstN,
    output cpuPkg::wordT instrAddr,
    input  cpuPkg::wordT instrData,
    output cpuPkg::wordT dataAddr,
    output logic         dataRead,
    output logic         dataWrite,
    input  cpuPkg::wordT dataIn,
    output cpuPkg::wordT dataOut,
    output cpuPkg::wordT numInst,
    output cpuPkg::wordT outputPort,
    output logic         outputValid,
    output logic         halted
);
    import cpuPkg::*;

    wordT    pc;
    wordT    pcPlusOne;
    wordT    ifIdInstr;
    wordT    ifIdPcPlusOne;
    logic    ifIdValid;
    logic    haltPend;      // HLT has left ID, fetch is over
    logic    fetchStop;

    ctrlT    decCtrl;
    ctrlT    idCtrl;
    ctrlT    idCtrlIn;
    regAddrT idRs;
    regAddrT idRt;
    regAddrT idDest;
    wordT    idImm;
    wordT    idTarget;
    wordT    rfA;
    wordT    rfB;
    wordT    idOpA;
    wordT    idOpB;

    logic    stall;
    logic    flush;
    logic    branchTaken;
    fwdSelT  idFwdA;
    fwdSelT  idFwdB;
    fwdSelT  exFwdA;
    fwdSelT  exFwdB;

    idExT    idEx;
    exMemT   exMem;
    memWbT   memWb;
    wordT    exOpA;
    wordT    exRegB;
    wordT    exOpB;
    wordT    exResult;
    wordT    wbData;

    function automatic wordT fwdMux(fwdSelT sel, wordT regVal, wordT exVal, wordT memVal,
                                    wordT wbVal);
        case (sel)
            fwdEx:   return exVal;
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign pcPlusOne = pc + 1'b1;
    assign instrAddr = pc;
    assign fetchStop = haltPend || idCtrl.isHalt;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc            <= '0;
            ifIdInstr     <= '0;
            ifIdPcPlusOne <= '0;
            ifIdValid     <= 1'b0;
        end else if (!stall) begin  // stall holds PC and IF/ID
            if (fetchStop) begin
                ifIdValid <= 1'b0;
            end else if (flush) begin
                pc        <= idTarget;
                ifIdValid <= 1'b0;  // kill the wrong-path fetch
            end else begin
                pc            <= pcPlusOne;
                ifIdInstr     <= instrData;
                ifIdPcPlusOne <= pcPlusOne;
                ifIdValid     <= 1'b1;
            end
        end
    end

    instrDecoder instrDecoder_i (
        .instr(ifIdInstr), .pcPlusOne(ifIdPcPlusOne), .ctrl(decCtrl),
        .rs(idRs), .rt(idRt), .dest(idDest), .imm(idImm), .target(idTarget)
    );

    regFile regFile_i (
        .clk(clk), .rstN(rstN), .rdAddrA(idRs), .rdAddrB(idRt),
        .wrAddr(memWb.dest), .wrData(wbData), .wrEn(memWb.ctrl.regWrite),
        .rdDataA(rfA), .rdDataB(rfB)
    );

    hazardUnit hazardUnit_i (
        .idCtrl(idCtrl), .idRs(idRs), .idRt(idRt), .idEx(idEx), .exMem(exMem),
        .memWb(memWb), .branchTaken(branchTaken), .stall(stall), .flush(flush),
        .idFwdA(idFwdA), .idFwdB(idFwdB), .exFwdA(exFwdA), .exFwdB(exFwdB)
    );

    assign idCtrl   = ifIdValid ? decCtrl : ctrlT'('0);
    assign idCtrlIn = stall ? ctrlT'('0) : idCtrl;  // bubble into EX

    // branch operands resolved here, in ID
    assign idOpA = fwdMux(idFwdA, rfA, exResult, exMem.aluResult, wbData);
    assign idOpB = fwdMux(idFwdB, rfB, exResult, exMem.aluResult, wbData);
    assign branchTaken = idCtrl.isBranch && ((idOpA == idOpB) == idCtrl.branchOnEq);

    // EX source is never selected at this stage
    assign exOpA  = fwdMux(exFwdA, idEx.opA, idEx.opA, exMem.aluResult, wbData);
    assign exRegB = fwdMux(exFwdB, idEx.opB, idEx.opB, exMem.aluResult, wbData);
    assign exOpB  = idEx.ctrl.aluSrcImm ? idEx.imm : exRegB;

    aluUnit aluUnit_i (.opA(exOpA), .opB(exOpB), .aluOp(idEx.ctrl.aluOp), .result(exResult));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            idEx  <= '0;
            exMem <= '0;
            memWb <= '0;
        end else begin
            idEx  <= '{ctrl: idCtrlIn, opA: idOpA, opB: idOpB, imm: idImm,
                       rs: idRs, rt: idRt, dest: idDest};
            exMem <= '{ctrl: idEx.ctrl, aluResult: exResult, storeData: exRegB,
                       opAVal: exOpA, dest: idEx.dest};
            memWb <= '{ctrl: exMem.ctrl, memData: dataIn, aluResult: exMem.aluResult,
                       opAVal: exMem.opAVal, dest: exMem.dest};
        end
    end

    assign dataAddr  = exMem.aluResult;
    assign dataRead  = exMem.ctrl.memRead;
    assign dataWrite = exMem.ctrl.memWrite;
    assign dataOut   = exMem.storeData;

    assign wbData      = memWb.ctrl.memToReg ? memWb.memData : memWb.aluResult;
    assign outputValid = memWb.ctrl.isWwd;
    assign outputPort  = memWb.opAVal;  // rs of the WWD

    // halted and the count both move on the edge where HLT retires
    always_ff @(posedge clk) begin
        if (!rstN) begin
            haltPend <= 1'b0;
            halted   <= 1'b0;
            numInst  <= '0;
        end else begin
            if (idCtrl.isHalt && !stall) haltPend <= 1'b1;
            if (memWb.ctrl.isHalt) halted <= 1'b1;
            if (memWb.ctrl.valid) numInst <= numInst + 1'b1;
        end
    end

endmodule

/* logic/cpuPkg.sv */
package cpuPkg;

    localparam int wordWidth    = 16;
    localparam int regAddrWidth = 2;
    localparam int numRegs      = 2 ** regAddrWidth;

    typedef logic [wordWidth-1:0]    wordT;
    typedef logic [regAddrWidth-1:0] regAddrT;

    // instr[15:12]
    typedef enum logic [3:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opAdi   = 4'd4,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opRtype = 4'd15
    } opcodeT;

    // instr[5:0] when opcode is opRtype
    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOrr = 6'd3,
        fnWwd = 6'd28,
        fnHlt = 6'd29
    } funcT;

    typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluOr} aluOpT;

    // operand source, newest writer wins
    typedef enum logic [1:0] {fwdReg, fwdWb, fwdMem, fwdEx} fwdSelT;

    typedef struct packed {
        logic  regWrite;
        logic  aluSrcImm;   // operand B from immediate
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  isWwd;
        logic  isHalt;
        logic  isBranch;
        logic  isJump;
        logic  branchOnEq;  // BEQ when set, BNE otherwise
        logic  valid;       // real instruction, not a bubble
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        ctrlT    ctrl;
        wordT    opA;
        wordT    opB;
        wordT    imm;
        regAddrT rs;
        regAddrT rt;
        regAddrT dest;
    } idExT;

    typedef struct packed {
        ctrlT    ctrl;
        wordT    aluResult;
        wordT    storeData;
        wordT    opAVal;    // rs value, carried for WWD
        regAddrT dest;
    } exMemT;

    typedef struct packed {
        ctrlT    ctrl;
        wordT    memData;
        wordT    aluResult;
        wordT    opAVal;
        regAddrT dest;
    } memWbT;

endpackage

/* logic/hazardUnit.sv */
`timescale 1ns/1ns

module hazardUnit (
    input  cpuPkg::ctrlT    idCtrl,
    input  cpuPkg::regAddrT idRs,
    input  cpuPkg::regAddrT idRt,
    input  cpuPkg::idExT    idEx,
    input  cpuPkg::exMemT   exMem,
    input  cpuPkg::memWbT   memWb,
    input  logic            branchTaken,
    output logic            stall,
    output logic            flush,
    output cpuPkg::fwdSelT  idFwdA,
    output cpuPkg::fwdSelT  idFwdB,
    output cpuPkg::fwdSelT  exFwdA,
    output cpuPkg::fwdSelT  exFwdB
);
    import cpuPkg::*;

    logic usesRs;
    logic usesRt;
    logic exMatch;
    logic memMatch;

    // loads are never picked here, their data is not ready
    function automatic fwdSelT pickSrc(regAddrT r, ctrlT exC, regAddrT exD, ctrlT memC,
                                       regAddrT memD, ctrlT wbC, regAddrT wbD);
        if (exC.regWrite && !exC.memRead && exD == r) return fwdEx;
        if (memC.regWrite && !memC.memRead && memD == r) return fwdMem;
        if (wbC.regWrite && wbD == r) return fwdWb;
        return fwdReg;
    endfunction

    assign usesRs = idCtrl.valid && !idCtrl.isJump && !idCtrl.isHalt;
    assign usesRt = usesRs && !idCtrl.isWwd && (!idCtrl.aluSrcImm || idCtrl.memWrite);

    assign exMatch  = (usesRs && idEx.dest == idRs) || (usesRt && idEx.dest == idRt);
    assign memMatch = (usesRs && exMem.dest == idRs) || (usesRt && exMem.dest == idRt);

    // load in EX blocks anyone; load in MEM blocks only a branch
    assign stall = (idEx.ctrl.memRead && exMatch)
                || (idCtrl.isBranch && exMem.ctrl.memRead && memMatch);
    assign flush = (branchTaken || idCtrl.isJump) && !stall;

    assign idFwdA = pickSrc(idRs, idEx.ctrl, idEx.dest, exMem.ctrl, exMem.dest,
                            memWb.ctrl, memWb.dest);
    assign idFwdB = pickSrc(idRt, idEx.ctrl, idEx.dest, exMem.ctrl, exMem.dest,
                            memWb.ctrl, memWb.dest);
    // EX stage has no younger writer to look at
    assign exFwdA = pickSrc(idEx.rs, ctrlT'('0), idEx.dest, exMem.ctrl, exMem.dest,
                            memWb.ctrl, memWb.dest);
    assign exFwdB = pickSrc(idEx.rt, ctrlT'('0), idEx.dest, exMem.ctrl, exMem.dest,
                            memWb.ctrl, memWb.dest);

endmodule

/* logic/instrDecoder.sv */
`timescale 1ns/1ns

module instrDecoder (
    input  cpuPkg::wordT    instr,
    input  cpuPkg::wordT    pcPlusOne,
    output cpuPkg::ctrlT    ctrl,
    output cpuPkg::regAddrT rs,
    output cpuPkg::regAddrT rt,
    output cpuPkg::regAddrT dest,
    output cpuPkg::wordT    imm,
    output cpuPkg::wordT    target
);
    import cpuPkg::*;

    opcodeT opcode;
    funcT   func;

    assign opcode = opcodeT'(instr[15:12]);
    assign func   = funcT'(instr[5:0]);
    assign rs     = instr[11:10];
    assign rt     = instr[9:8];
    assign dest   = (opcode == opRtype) ? instr[7:6] : instr[9:8];  // rt for ADI and LWD
    assign imm    = {{(wordWidth - 8){instr[7]}}, instr[7:0]};

    // JMP keeps the upper PC bits
    assign target = (opcode == opJmp) ? {pcPlusOne[wordWidth-1:12], instr[11:0]}
                                      : pcPlusOne + imm;

    always_comb begin
        ctrl       = '0;
        ctrl.valid = 1'b1;
        case (opcode)
            opAdi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opLwd: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
            end
            opSwd: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
            end
            opBne, opBeq: begin
                ctrl.isBranch   = 1'b1;
                ctrl.branchOnEq = (opcode == opBeq);
            end
            opJmp: ctrl.isJump = 1'b1;
            opRtype: begin
                case (func)
                    fnAdd: ctrl.regWrite = 1'b1;
                    fnSub: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluSub;
                    end
                    fnAnd: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluAnd;
                    end
                    fnOrr: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluOr;
                    end
                    fnWwd: ctrl.isWwd = 1'b1;
                    fnHlt: ctrl.isHalt = 1'b1;
                    default: ctrl = '0;  // unknown function, bubble
                endcase
            end
            default: ctrl = '0;
        endcase
    end

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ns

module regFile (
    input  logic            clk,
    input  logic            rstN,
    input  cpuPkg::regAddrT rdAddrA,
    input  cpuPkg::regAddrT rdAddrB,
    input  cpuPkg::regAddrT wrAddr,
    input  cpuPkg::wordT    wrData,
    input  logic            wrEn,
    output cpuPkg::wordT    rdDataA,
    output cpuPkg::wordT    rdDataB
);
    import cpuPkg::*;

    wordT regs [numRegs];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // write-through so WB and ID can share a cycle
    assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
    assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

/* test/cpuDatapath_sva.sv */
`timescale 1ns/1ns

module cpuDatapathSva (
    input logic clk,
    input logic rstN,
    input logic dataRead,
    input logic dataWrite,
    input logic outputValid,
    input logic halted
);

    // only one instruction sits in MEM
    strobeExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(dataRead && dataWrite))
        else $error("dataRead and dataWrite high in the same cycle");

    haltSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
        else $error("halted fell without a reset");

    // all work ahead of HLT has retired by then
    quietAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
        halted |-> !outputValid)
        else $error("outputValid pulsed after halt");

    strobesKnown: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown({dataRead, dataWrite, outputValid, halted}))
        else $error("unknown value on a strobe");

endmodule

bind cpuDatapath cpuDatapathSva cpuDatapathSva_i (
    .clk(clk),
    .rstN(rstN),
    .dataRead(dataRead),
    .dataWrite(dataWrite),
    .outputValid(outputValid),
    .halted(halted)
);

/* test/cpuDatapath_tb.sv */
`timescale 1ns/1ns

module cpuDatapath_tb;
    import cpuPkg::*;

    localparam int clkPeriod     = 4;
    localparam int numTests      = 6;
    localparam int cyclesPerTest = 200;

    logic clk;
    logic rstN;
    wordT instrAddr;
    wordT instrData;
    wordT dataAddr;
    logic dataRead;
    logic dataWrite;
    wordT dataIn;
    wordT dataOut;
    wordT numInst;
    wordT outputPort;
    logic outputValid;
    logic halted;

    wordT   imem [256];
    wordT   dmem [256];
    wordT   refMem [256];  // model copy of data memory
    wordT   gotOut [$];
    wordT   expOut [$];
    int     expCount;
    int     outAfterHalt;
    int     loadPtr;
    integer seed;

    cpuDatapath cpuDatapath_i (.*);

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    // both memories answer in the same cycle
    assign instrData = imem[instrAddr[7:0]];
    assign dataIn    = dataRead ? dmem[dataAddr[7:0]] : 'x;  // no data without a read strobe

    always @(posedge clk) begin
        if (dataWrite) dmem[dataAddr[7:0]] <= dataOut;
    end

    always @(negedge clk) begin  // mid-cycle, WWD pulse is stable
        if (rstN && outputValid) begin
            gotOut.push_back(outputPort);
            if (halted) outAfterHalt++;
        end
    end

    task automatic abortRun();
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            abortRun();
        end
    endtask

    // every address bit shows up in the word
    function automatic wordT fillWord(int addr);
        return wordT'(addr * 16'h0101) ^ 16'hc3a5;
    endfunction

    function automatic wordT rTypeWord(funcT fn, int rs, int rt, int rd);
        return {opRtype, rs[1:0], rt[1:0], rd[1:0], fn};
    endfunction

    function automatic wordT immWord(opcodeT op, int rs, int rt, int imm);
        return {op, rs[1:0], rt[1:0], imm[7:0]};
    endfunction

    function automatic wordT jumpWord(int addr);
        return {opJmp, addr[11:0]};
    endfunction

    task automatic put(input wordT w);
        imem[loadPtr] = w;
        loadPtr++;
    endtask

    // plain sequential ISA model, one instruction per step
    task automatic runModel();
        wordT r [4];
        wordT pc;
        wordT ins;
        wordT a;
        wordT b;
        wordT sImm;
        wordT addr;
        logic done;
        int   steps;
        r = '{default: '0};
        pc = '0;
        done = 1'b0;
        steps = 0;
        expOut = {};
        expCount = 0;
        while (!done && steps < 1000) begin
            ins  = imem[pc[7:0]];
            a    = r[ins[11:10]];
            b    = r[ins[9:8]];
            sImm = {{8{ins[7]}}, ins[7:0]};
            addr = a + sImm;
            pc   = pc + 16'd1;
            expCount++;
            steps++;
            case (ins[15:12])
                4'd0: if (a != b) pc = pc + sImm;  // BNE
                4'd1: if (a == b) pc = pc + sImm;  // BEQ
                4'd4: r[ins[9:8]] = addr;
                4'd7: r[ins[9:8]] = refMem[addr[7:0]];
                4'd8: refMem[addr[7:0]] = b;
                4'd9: pc = {pc[15:12], ins[11:0]};
                4'd15: begin
                    case (ins[5:0])
                        6'd0:  r[ins[7:6]] = a + b;
                        6'd1:  r[ins[7:6]] = a - b;
                        6'd2:  r[ins[7:6]] = a & b;
                        6'd3:  r[ins[7:6]] = a | b;
                        6'd28: expOut.push_back(a);
                        6'd29: done = 1'b1;
                    endcase
                end
            endcase
        end
    endtask

    task automatic startTest();
        for (int i = 0; i < 256; i++) begin
            imem[i]   = rTypeWord(fnHlt, 0, 0, 0);  // unused slots halt
            dmem[i]  <= fillWord(i);
            refMem[i] = fillWord(i);
        end
        loadPtr = 0;
        @(posedge clk);
        #1;
        rstN = 1'b0;
    endtask

    task automatic finishTest(input string name);
        int waited;
        repeat (3) @(posedge clk);
        #1;
        gotOut = {};
        outAfterHalt = 0;
        rstN = 1'b1;
        runModel();
        waited = 0;
        while (!halted && waited < cyclesPerTest) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!halted) begin
            $display("Timeout: %s did not halt within %0d cycles", name, cyclesPerTest);
            abortRun();
        end
        repeat (2) @(posedge clk);
        #1;
        checkEq(gotOut.size(), expOut.size(), {name, ": output count"});
        foreach (expOut[k]) checkEq(gotOut[k], expOut[k], $sformatf("%s: output %0d", name, k));
        checkEq(numInst, expCount, {name, ": retired count"});
        checkEq(outAfterHalt, 0, {name, ": output after halt"});
        for (int i = 0; i < 256; i++) begin
            checkEq(dmem[i], refMem[i], $sformatf("%s: data word %0d", name, i));
        end
    endtask

    task automatic aluForwarding();
        startTest();
        put(immWord(opAdi, 0, 1, 8'h35));
        put(rTypeWord(fnWwd, 1, 0, 0));  // EX forward into WWD
        put(immWord(opAdi, 1, 2, -18));  // r1 two back, MEM forward
        put(rTypeWord(fnWwd, 2, 0, 0));
        put(rTypeWord(fnAdd, 1, 2, 3));
        put(rTypeWord(fnSub, 3, 1, 1));  // back to back
        put(rTypeWord(fnWwd, 1, 0, 0));
        put(rTypeWord(fnAnd, 1, 3, 2));
        put(rTypeWord(fnOrr, 2, 3, 0));
        put(rTypeWord(fnWwd, 0, 0, 0));
        put(rTypeWord(fnWwd, 2, 0, 0));
        put(rTypeWord(fnWwd, 3, 0, 0));
        put(rTypeWord(fnHlt, 0, 0, 0));
        finishTest("alu forwarding");
    endtask

    task automatic loadUse();
        startTest();
        put(immWord(opAdi, 0, 1, 8'h2a));
        put(immWord(opAdi, 0, 2, 8'h10));
        put(immWord(opSwd, 2, 1, 3));   // mem[19] = r1
        put(immWord(opLwd, 2, 3, 3));
        put(rTypeWord(fnAdd, 3, 1, 0));  // load-use stall
        put(rTypeWord(fnWwd, 3, 0, 0));
        put(rTypeWord(fnWwd, 0, 0, 0));
        put(immWord(opLwd, 2, 1, -16));  // preset word at 0
        put(rTypeWord(fnWwd, 1, 0, 0));
        put(rTypeWord(fnHlt, 0, 0, 0));
        finishTest("load-use");
        checkEq(dmem[19], 16'h002a, "load-use: stored word");
    endtask

    task automatic branchPaths();
        startTest();
        put(immWord(opAdi, 0, 1, 3));
        put(immWord(opAdi, 0, 2, 3));
        put(immWord(opBeq, 1, 2, 1));   // taken, r2 still in EX
        put(rTypeWord(fnWwd, 0, 0, 0));  // wrong path
        put(immWord(opBne, 1, 2, 1));   // not taken
        put(rTypeWord(fnWwd, 1, 0, 0));
        put(immWord(opBeq, 1, 0, 1));   // not taken
        put(rTypeWord(fnWwd, 2, 0, 0));
        put(immWord(opBne, 1, 0, 1));   // taken
        put(rTypeWord(fnWwd, 0, 0, 0));
        put(jumpWord(12));
        put(rTypeWord(fnWwd, 0, 0, 0));
        put(immWord(opAdi, 3, 3, 1));   // loop body at 12
        put(rTypeWord(fnWwd, 3, 0, 0));
        put(immWord(opBne, 3, 1, -3));
        put(rTypeWord(fnHlt, 0, 0, 0));
        finishTest("branches");
    endtask

    task automatic branchOnLoad();
        startTest();
        put(immWord(opAdi, 0, 1, 8'h20));
        put(immWord(opAdi, 0, 2, 7));
        put(immWord(opSwd, 1, 2, 0));
        put(immWord(opLwd, 1, 3, 0));
        put(immWord(opBeq, 3, 2, 1));   // load right before the branch
        put(rTypeWord(fnWwd, 1, 0, 0));
        put(immWord(opLwd, 1, 0, 1));
        put(immWord(opAdi, 1, 1, 0));
        put(immWord(opBne, 0, 3, 1));   // load in MEM
        put(rTypeWord(fnWwd, 3, 0, 0));
        put(rTypeWord(fnWwd, 0, 0, 0));
        put(rTypeWord(fnHlt, 0, 0, 0));
        finishTest("branch on load");
    endtask

    task automatic randomProgram();
        int rnd;
        startTest();
        for (int k = 0; k < 30; k++) begin
            rnd = $random(seed);
            case (rnd[31:24] % 8'd6)
                0: put(rTypeWord(fnAdd, rnd[1:0], rnd[3:2], rnd[5:4]));
                1: put(rTypeWord(fnSub, rnd[1:0], rnd[3:2], rnd[5:4]));
                2: put(rTypeWord(fnAnd, rnd[1:0], rnd[3:2], rnd[5:4]));
                3: put(rTypeWord(fnOrr, rnd[1:0], rnd[3:2], rnd[5:4]));
                4: put(immWord(opAdi, rnd[1:0], rnd[3:2], rnd[23:16]));
                default: put(rTypeWord(fnWwd, rnd[1:0], 0, 0));
            endcase
        end
        for (int r = 0; r < 4; r++) begin
            put(rTypeWord(fnWwd, r, 0, 0));
        end
        put(rTypeWord(fnHlt, 0, 0, 0));
        finishTest("random");
    endtask

    task automatic haltBehavior();
        wordT pcAtHalt;
        startTest();
        put(immWord(opAdi, 0, 1, 9));
        put(rTypeWord(fnWwd, 1, 0, 0));  // still in flight at HLT fetch
        put(rTypeWord(fnHlt, 0, 0, 0));
        put(rTypeWord(fnWwd, 1, 0, 0));
        put(immWord(opAdi, 1, 1, 1));
        finishTest("halt");
        pcAtHalt = instrAddr;
        repeat (10) @(posedge clk);
        #1;
        checkEq(halted, 1'b1, "halt: halted stays high");
        checkEq(numInst, expCount, "halt: retired count");
        checkEq(instrAddr, pcAtHalt, "halt: fetch address frozen");
        checkEq(outAfterHalt, 0, "halt: output after halt");
    endtask

    initial begin
        rstN = 1'b0;
        seed = 32'hb767_779c;
        aluForwarding();
        loadUse();
        branchPaths();
        branchOnLoad();
        randomProgram();
        haltBehavior();
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // watchdog, whole sequence plus reset slack
    initial begin
        #(numTests * (cyclesPerTest + 20) * clkPeriod);
        $display("Timeout: the test sequence ran past its time budget");
        abortRun();
    end

endmodule
